// File: afu_pkg.sv
/* AFU job, descriptor and memory types */
`default_nettype none

package afu_pkg;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 64;
  localparam int MAX_COUNT  = 64;
  localparam int COUNT_W    = $clog2(MAX_COUNT + 1);
  localparam int WORD_BYTES = 8;

  // Host job interface
  typedef struct packed {
    logic              start;
    logic [ADDR_W-1:0] wed_addr;
  } job_in_t;

  typedef struct packed {
    logic running;
    logic done;
  } job_out_t;

  // Decoded work element descriptor
  // Word 0: count in [63:32], source in [31:0]; word 1: destination in [31:0]
  typedef struct packed {
    logic [ADDR_W-1:0] src;
    logic [31:0]       count;
    logic [ADDR_W-1:0] dst;
  } wed_t;

  // Memory port, four-phase req/ack
  typedef struct packed {
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              error;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: mmio_pkg.sv
/* MMIO register map */
`default_nettype none

package mmio_pkg;

  localparam int MMIO_DATA_W = 64;

  localparam logic [1:0] REG_STATUS = 2'd0;
  localparam logic [1:0] REG_ERROR  = 2'd1;
  localparam logic [1:0] REG_RESULT = 2'd2;
  localparam logic [1:0] REG_CTRL   = 2'd3;

  // Bit positions in the error word
  localparam int ERR_WED_READ  = 0;
  localparam int ERR_SUM_READ  = 1;
  localparam int ERR_SUM_WRITE = 2;
  localparam int ERR_COUNT     = 3;

  // Bit positions in the status word
  localparam int STAT_RUNNING = 0;
  localparam int STAT_DONE    = 1;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [1:0]             index;
    logic [MMIO_DATA_W-1:0] wdata;
  } mmio_req_t;

  typedef struct packed {
    logic                   valid;
    logic [MMIO_DATA_W-1:0] rdata;
  } mmio_rsp_t;

  typedef struct packed {
    logic [MMIO_DATA_W-2:0] reserved;
    logic                   soft_reset;
  } ctrl_word_t;

  typedef struct packed {
    logic [MMIO_DATA_W-5:0] reserved;
    logic [3:0]             clear_mask;
  } err_ack_word_t;

  // Write word, decoded by register index
  typedef union packed {
    ctrl_word_t    ctrl;
    err_ack_word_t err_ack;
  } mmio_wdata_u;

endpackage

`default_nettype wire

// File: job_control.sv
/* Job sequencer */
`default_nettype none

module job_control import afu_pkg::*, mmio_pkg::*; (
  input  logic       clock,
  input  logic       rst,
  input  job_in_t    job_in,
  output job_out_t   job_out,
  input  logic       soft_reset,
  output logic       core_rst,
  output logic       wed_req,
  input  logic       wed_ack,
  input  wed_t       wed,
  input  logic       wed_error,
  output logic       sum_req,
  input  logic       sum_ack,
  input  logic [1:0] sum_errors,
  output logic       job_done_pulse,
  output logic [3:0] err_set
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_CHECK,
    ST_COMPUTE,
    ST_DONE
  } state_t;

  state_t state;
  logic   job_rst;

  assign job_rst = rst | soft_reset;

  // Datapath reset lags the sequencer by one cycle
  always_ff @(posedge clock) begin
    core_rst <= job_rst;
  end

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  always_ff @(posedge clock) begin
    if (job_rst) begin
      state          <= ST_IDLE;
      job_out        <= '0;
      job_done_pulse <= 1'b0;
      err_set        <= '0;
    end else begin
      job_done_pulse <= 1'b0;
      err_set        <= '0;
      case (state)
        ST_IDLE: begin
          if (job_in.start) begin
            job_out.running <= 1'b1;
            job_out.done    <= 1'b0;
            state           <= ST_FETCH;
          end
        end
        ST_FETCH: begin
          if (wed_ack) begin
            state <= ST_CHECK;
          end
        end
        ST_CHECK: begin
          // Fetch handshake closes before the descriptor is judged
          if (!wed_ack) begin
            if (wed_error) begin
              err_set[ERR_WED_READ] <= 1'b1;
              state                 <= ST_DONE;
            end else if (wed.count > 32'(MAX_COUNT)) begin
              err_set[ERR_COUNT] <= 1'b1;
              state              <= ST_DONE;
            end else begin
              state <= ST_COMPUTE;
            end
          end
        end
        ST_COMPUTE: begin
          if (sum_ack) begin
            err_set[ERR_SUM_READ]  <= sum_errors[0];
            err_set[ERR_SUM_WRITE] <= sum_errors[1];
            state                  <= ST_DONE;
          end
        end
        ST_DONE: begin
          job_out.running <= 1'b0;
          job_out.done    <= 1'b1;
          job_done_pulse  <= 1'b1;
          state           <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  assign wed_req = (state == ST_FETCH);
  assign sum_req = (state == ST_COMPUTE);

  a_run_done_excl: assert property (@(posedge clock) disable iff (job_rst)
    !(job_out.running && job_out.done));

endmodule

`default_nettype wire

// File: wed_fetch.sv
/* Descriptor fetch */
`default_nettype none

module wed_fetch import afu_pkg::*; (
  input  logic              clock,
  input  logic              core_rst,
  input  logic              wed_req,
  output logic              wed_ack,
  input  logic [ADDR_W-1:0] wed_addr,
  output wed_t              wed,
  output logic              wed_error,
  output mem_req_t          mem_req_o,
  output logic              mem_req,
  input  logic              mem_ack,
  input  mem_rsp_t          mem_rsp
);

  typedef enum logic [2:0] {
    FS_IDLE,
    FS_WORD0,
    FS_GAP,
    FS_WORD1,
    FS_CLOSE,
    FS_ACK
  } fetch_state_t;

  fetch_state_t state;

  always_ff @(posedge clock) begin
    if (core_rst) begin
      state     <= FS_IDLE;
      mem_req   <= 1'b0;
      wed_ack   <= 1'b0;
      wed_error <= 1'b0;
    end else begin
      case (state)
        FS_IDLE: begin
          if (wed_req) begin
            mem_req_o <= '{write: 1'b0, addr: wed_addr, wdata: '0};
            mem_req   <= 1'b1;
            wed_error <= 1'b0;
            state     <= FS_WORD0;
          end
        end
        FS_WORD0: begin
          if (mem_ack) begin
            wed.src   <= mem_rsp.rdata[ADDR_W-1:0];
            wed.count <= mem_rsp.rdata[DATA_W-1:32];
            wed_error <= mem_rsp.error;
            mem_req   <= 1'b0;
            state     <= FS_GAP;
          end
        end
        FS_GAP: begin
          // Second word sits right behind the first
          if (!mem_ack) begin
            mem_req_o.addr <= mem_req_o.addr + ADDR_W'(WORD_BYTES);
            mem_req        <= 1'b1;
            state          <= FS_WORD1;
          end
        end
        FS_WORD1: begin
          if (mem_ack) begin
            wed.dst   <= mem_rsp.rdata[ADDR_W-1:0];
            wed_error <= wed_error | mem_rsp.error;
            mem_req   <= 1'b0;
            state     <= FS_CLOSE;
          end
        end
        FS_CLOSE: begin
          if (!mem_ack) begin
            wed_ack <= 1'b1;
            state   <= FS_ACK;
          end
        end
        FS_ACK: begin
          if (!wed_req) begin
            wed_ack <= 1'b0;
            state   <= FS_IDLE;
          end
        end
        default: state <= FS_IDLE;
      endcase
    end
  end

  a_req_held: assert property (@(posedge clock) disable iff (core_rst)
    $fell(wed_req) |-> $past(wed_ack));

endmodule

`default_nettype wire

// File: sum_unit.sv
/* Summing unit */
`default_nettype none

module sum_unit import afu_pkg::*; (
  input  logic              clock,
  input  logic              core_rst,
  input  logic              sum_req,
  output logic              sum_ack,
  input  wed_t              wed,
  output logic [DATA_W-1:0] sum,
  output logic [1:0]        sum_errors,
  output mem_req_t          mem_req_o,
  output logic              mem_req,
  input  logic              mem_ack,
  input  mem_rsp_t          mem_rsp
);

  typedef enum logic [2:0] {
    SS_IDLE,
    SS_READ,
    SS_RGAP,
    SS_WRITE,
    SS_WGAP,
    SS_ACK
  } sum_state_t;

  sum_state_t         state;
  logic [COUNT_W-1:0] remaining;
  logic               rd_error;
  logic               wr_error;

  assign sum_errors = {wr_error, rd_error};

  always_ff @(posedge clock) begin
    if (core_rst) begin
      state    <= SS_IDLE;
      mem_req  <= 1'b0;
      sum_ack  <= 1'b0;
      rd_error <= 1'b0;
      wr_error <= 1'b0;
    end else begin
      case (state)
        SS_IDLE: begin
          if (sum_req) begin
            sum       <= '0;
            remaining <= wed.count[COUNT_W-1:0];
            rd_error  <= 1'b0;
            wr_error  <= 1'b0;
            mem_req   <= 1'b1;
            // Empty run goes straight to the write of a zero sum
            if (wed.count == '0) begin
              mem_req_o <= '{write: 1'b1, addr: wed.dst, wdata: '0};
              state     <= SS_WRITE;
            end else begin
              mem_req_o <= '{write: 1'b0, addr: wed.src, wdata: '0};
              state     <= SS_READ;
            end
          end
        end
        SS_READ: begin
          if (mem_ack) begin
            sum       <= sum + mem_rsp.rdata;
            rd_error  <= mem_rsp.error;
            remaining <= remaining - 1'b1;
            mem_req   <= 1'b0;
            state     <= SS_RGAP;
          end
        end
        SS_RGAP: begin
          if (!mem_ack) begin
            if (rd_error) begin
              // Stop at the first bad read, no write
              sum_ack <= 1'b1;
              state   <= SS_ACK;
            end else if (remaining == '0) begin
              mem_req_o <= '{write: 1'b1, addr: wed.dst, wdata: sum};
              mem_req   <= 1'b1;
              state     <= SS_WRITE;
            end else begin
              mem_req_o.addr <= mem_req_o.addr + ADDR_W'(WORD_BYTES);
              mem_req        <= 1'b1;
              state          <= SS_READ;
            end
          end
        end
        SS_WRITE: begin
          if (mem_ack) begin
            wr_error <= mem_rsp.error;
            mem_req  <= 1'b0;
            state    <= SS_WGAP;
          end
        end
        SS_WGAP: begin
          if (!mem_ack) begin
            sum_ack <= 1'b1;
            state   <= SS_ACK;
          end
        end
        SS_ACK: begin
          if (!sum_req) begin
            sum_ack <= 1'b0;
            state   <= SS_IDLE;
          end
        end
        default: state <= SS_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: mem_arbiter.sv
/* Memory port arbiter */
`default_nettype none

module mem_arbiter import afu_pkg::*; (
  input  logic     clock,
  input  logic     core_rst,
  input  mem_req_t wed_cmd,
  input  logic     wed_req,
  output logic     wed_ack,
  output mem_rsp_t wed_rsp,
  input  mem_req_t sum_cmd,
  input  logic     sum_req,
  output logic     sum_ack,
  output mem_rsp_t sum_rsp,
  output mem_req_t mem_req_o,
  output logic     mem_req,
  input  logic     mem_ack,
  input  mem_rsp_t mem_rsp
);

  typedef enum logic [1:0] {
    GNT_NONE,
    GNT_WED,
    GNT_SUM
  } grant_t;

  grant_t grant;

  // Grant holds until the owner's req and the memory ack have both dropped
  always_ff @(posedge clock) begin
    if (core_rst) begin
      grant <= GNT_NONE;
    end else begin
      case (grant)
        GNT_NONE: begin
          if (wed_req) begin
            grant <= GNT_WED;
          end else if (sum_req) begin
            grant <= GNT_SUM;
          end
        end
        GNT_WED: begin
          if (!wed_req && !mem_ack) begin
            grant <= GNT_NONE;
          end
        end
        GNT_SUM: begin
          if (!sum_req && !mem_ack) begin
            grant <= GNT_NONE;
          end
        end
        default: grant <= GNT_NONE;
      endcase
    end
  end

  always_comb begin
    mem_req_o = (grant == GNT_SUM) ? sum_cmd : wed_cmd;
    mem_req   = ((grant == GNT_WED) && wed_req) || ((grant == GNT_SUM) && sum_req);
  end

  assign wed_ack = (grant == GNT_WED) && mem_ack;
  assign sum_ack = (grant == GNT_SUM) && mem_ack;
  assign wed_rsp = (grant == GNT_WED) ? mem_rsp : '0;
  assign sum_rsp = (grant == GNT_SUM) ? mem_rsp : '0;

  a_cmd_stable: assert property (@(posedge clock) disable iff (core_rst)
    mem_req && $past(mem_req) |-> mem_req_o == $past(mem_req_o));

endmodule

`default_nettype wire

// File: mmio_regs.sv
/* MMIO register file */
`default_nettype none

module mmio_regs import afu_pkg::*, mmio_pkg::*; (
  input  logic              clock,
  input  logic              rst,
  input  mmio_req_t         mmio_in,
  output mmio_rsp_t         mmio_out,
  input  job_out_t          job_out,
  input  logic [DATA_W-1:0] sum,
  input  logic              job_done_pulse,
  input  logic [3:0]        err_set,
  output logic              soft_reset
);

  mmio_wdata_u            wword;
  logic                   wr_en;
  logic                   rd_en;
  logic [3:0]             err_bits;
  logic [3:0]             err_clear;
  logic [DATA_W-1:0]      result;
  logic [MMIO_DATA_W-1:0] rd_mux;

  assign wword = mmio_in.wdata;
  assign wr_en = mmio_in.valid && mmio_in.write;
  assign rd_en = mmio_in.valid && !mmio_in.write;

  // Error acknowledge clears only the masked bits
  assign err_clear = (wr_en && mmio_in.index == REG_ERROR) ? wword.err_ack.clear_mask : '0;

  always_ff @(posedge clock) begin
    if (rst) begin
      soft_reset <= 1'b0;
    end else begin
      soft_reset <= wr_en && (mmio_in.index == REG_CTRL) && wword.ctrl.soft_reset;
    end
  end

  // New faults win over a clear in the same cycle
  always_ff @(posedge clock) begin
    if (rst || soft_reset) begin
      err_bits <= '0;
    end else begin
      err_bits <= (err_bits & ~err_clear) | err_set;
    end
  end

  always_ff @(posedge clock) begin
    if (job_done_pulse) begin
      result <= sum;
    end
  end

  //////////////////////////////
  // Read path
  //////////////////////////////

  always_comb begin
    rd_mux = '0;
    case (mmio_in.index)
      REG_STATUS: begin
        rd_mux[STAT_RUNNING] = job_out.running;
        rd_mux[STAT_DONE]    = job_out.done;
      end
      REG_ERROR:  rd_mux = MMIO_DATA_W'(err_bits);
      REG_RESULT: rd_mux = result;
      default:    rd_mux = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      mmio_out.valid <= 1'b0;
    end else begin
      mmio_out.valid <= rd_en;
    end
  end

  always_ff @(posedge clock) begin
    if (rd_en) begin
      mmio_out.rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: afu_top.sv
/* Accelerator top level */
`default_nettype none

module afu_top import afu_pkg::*, mmio_pkg::*; (
  input  logic      clock,
  input  logic      rst,
  input  job_in_t   job_in,
  output job_out_t  job_out,
  output mem_req_t  mem_req_o,
  output logic      mem_req,
  input  logic      mem_ack,
  input  mem_rsp_t  mem_rsp,
  input  mmio_req_t mmio_in,
  output mmio_rsp_t mmio_out
);

  logic              soft_reset;
  logic              core_rst;
  logic              wed_req;
  logic              wed_ack;
  wed_t              wed;
  logic              wed_error;
  logic              sum_req;
  logic              sum_ack;
  logic [DATA_W-1:0] sum;
  logic [1:0]        sum_errors;
  logic              job_done_pulse;
  logic [3:0]        err_set;
  mem_req_t          wed_cmd;
  logic              wed_mreq;
  logic              wed_mack;
  mem_rsp_t          wed_rsp;
  mem_req_t          sum_cmd;
  logic              sum_mreq;
  logic              sum_mack;
  mem_rsp_t          sum_rsp;

  //////////////////////////////
  // Control
  //////////////////////////////

  job_control u_job_control (
    .clock          (clock),
    .rst            (rst),
    .job_in         (job_in),
    .job_out        (job_out),
    .soft_reset     (soft_reset),
    .core_rst       (core_rst),
    .wed_req        (wed_req),
    .wed_ack        (wed_ack),
    .wed            (wed),
    .wed_error      (wed_error),
    .sum_req        (sum_req),
    .sum_ack        (sum_ack),
    .sum_errors     (sum_errors),
    .job_done_pulse (job_done_pulse),
    .err_set        (err_set)
  );

  mmio_regs u_mmio_regs (
    .clock          (clock),
    .rst            (rst),
    .mmio_in        (mmio_in),
    .mmio_out       (mmio_out),
    .job_out        (job_out),
    .sum            (sum),
    .job_done_pulse (job_done_pulse),
    .err_set        (err_set),
    .soft_reset     (soft_reset)
  );

  //////////////////////////////
  // Datapath
  //////////////////////////////

  // WED address is held by the host for the whole job
  wed_fetch u_wed_fetch (
    .clock     (clock),
    .core_rst  (core_rst),
    .wed_req   (wed_req),
    .wed_ack   (wed_ack),
    .wed_addr  (job_in.wed_addr),
    .wed       (wed),
    .wed_error (wed_error),
    .mem_req_o (wed_cmd),
    .mem_req   (wed_mreq),
    .mem_ack   (wed_mack),
    .mem_rsp   (wed_rsp)
  );

  sum_unit u_sum_unit (
    .clock      (clock),
    .core_rst   (core_rst),
    .sum_req    (sum_req),
    .sum_ack    (sum_ack),
    .wed        (wed),
    .sum        (sum),
    .sum_errors (sum_errors),
    .mem_req_o  (sum_cmd),
    .mem_req    (sum_mreq),
    .mem_ack    (sum_mack),
    .mem_rsp    (sum_rsp)
  );

  mem_arbiter u_mem_arbiter (
    .clock     (clock),
    .core_rst  (core_rst),
    .wed_cmd   (wed_cmd),
    .wed_req   (wed_mreq),
    .wed_ack   (wed_mack),
    .wed_rsp   (wed_rsp),
    .sum_cmd   (sum_cmd),
    .sum_req   (sum_mreq),
    .sum_ack   (sum_mack),
    .sum_rsp   (sum_rsp),
    .mem_req_o (mem_req_o),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rsp   (mem_rsp)
  );

endmodule

`default_nettype wire

// File: tb_mem_model.sv
/* Testbench memory model */
`default_nettype none

module tb_mem_model import afu_pkg::*; (
  input  logic              clock,
  input  logic              rst,
  input  mem_req_t          mem_req_o,
  input  logic              mem_req,
  output logic              mem_ack,
  output mem_rsp_t          mem_rsp,
  input  logic [3:0]        ack_delay,
  input  logic              err_en,
  input  logic [ADDR_W-1:0] err_addr,
  input  logic              host_we,
  input  logic [ADDR_W-1:0] host_addr,
  input  logic [DATA_W-1:0] host_wdata
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS = 256;
  localparam int IDX_W     = $clog2(MEM_WORDS);

  logic [DATA_W-1:0] mem [MEM_WORDS];
  logic              ack_q = 1'b0;
  mem_rsp_t          rsp_q = '0;
  logic              pending = 1'b0;
  logic [3:0]        wait_cnt = '0;
  logic [IDX_W-1:0]  idx;
  logic              hit_err;

  assign mem_ack = ack_q;
  assign mem_rsp = rsp_q;
  assign idx     = mem_req_o.addr[IDX_W+2:3];
  assign hit_err = err_en && (mem_req_o.addr == err_addr);

  always @(posedge clock) begin
    // Host side loads descriptors and markers between jobs
    if (host_we) begin
      mem[host_addr[IDX_W+2:3]] <= host_wdata;
    end
    if (rst) begin
      ack_q   <= 1'b0;
      pending <= 1'b0;
      rsp_q   <= '0;
    end else if (ack_q) begin
      // Hold the response until the requester lets go
      if (!mem_req) begin
        ack_q <= 1'b0;
      end
    end else if (mem_req) begin
      if (!pending) begin
        pending  <= 1'b1;
        wait_cnt <= ack_delay;
      end else if (wait_cnt != '0) begin
        wait_cnt <= wait_cnt - 4'd1;
      end else begin
        pending       <= 1'b0;
        ack_q         <= 1'b1;
        rsp_q.error   <= hit_err;
        rsp_q.rdata   <= mem_req_o.write ? '0 : mem[idx];
        // A faulted write leaves the word untouched
        if (mem_req_o.write && !hit_err) begin
          mem[idx] <= mem_req_o.wdata;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: tb_afu.sv
/* AFU testbench */
`default_nettype none

module tb_afu import afu_pkg::*, mmio_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MEM_WORDS    = 256;
  localparam int IDX_W        = $clog2(MEM_WORDS);
  localparam int NUM_JOBS     = 12;
  localparam int DONE_TIMEOUT = 5000;
  localparam int IDLE_TIMEOUT = 10;

  typedef struct packed {
    logic [31:0] wed_addr;
    logic [31:0] src;
    logic [31:0] count;
    logic [31:0] dst;
    logic        inject;
    logic [31:0] err_addr;
    logic [3:0]  exp_err;
    logic        soft_reset;
    logic        rand_delay;
  } job_entry_t;

  logic        clock;
  logic        rst;
  job_in_t     job_in;
  job_out_t    job_out;
  mem_req_t    mem_req_o;
  logic        mem_req;
  logic        mem_ack;
  mem_rsp_t    mem_rsp;
  mmio_req_t   mmio_in;
  mmio_rsp_t   mmio_out;
  logic [3:0]  ack_delay;
  logic        err_en;
  logic [31:0] err_addr;
  logic        host_we;
  logic [31:0] host_addr;
  logic [63:0] host_wdata;

  job_entry_t  jobs [NUM_JOBS];
  logic [63:0] shadow [MEM_WORDS];
  logic [31:0] lfsr;
  logic        rand_mode;
  logic        timed_out;
  int          errors;
  int          checks;

  afu_top UUT (
    .clock     (clock),
    .rst       (rst),
    .job_in    (job_in),
    .job_out   (job_out),
    .mem_req_o (mem_req_o),
    .mem_req   (mem_req),
    .mem_ack   (mem_ack),
    .mem_rsp   (mem_rsp),
    .mmio_in   (mmio_in),
    .mmio_out  (mmio_out)
  );

  tb_mem_model u_mem (
    .clock      (clock),
    .rst        (rst),
    .mem_req_o  (mem_req_o),
    .mem_req    (mem_req),
    .mem_ack    (mem_ack),
    .mem_rsp    (mem_rsp),
    .ack_delay  (ack_delay),
    .err_en     (err_en),
    .err_addr   (err_addr),
    .host_we    (host_we),
    .host_addr  (host_addr),
    .host_wdata (host_wdata)
  );

  always #50 clock = ~clock;

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      v    = {v[62:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Reference sum straight from the memory copy
  function automatic logic [63:0] sum_words(input logic [31:0] src, input logic [31:0] count);
    logic [63:0] acc;
    int          base;
    acc  = '0;
    base = int'(src >> 3);
    for (int k = 0; k < int'(count); k++) begin
      acc = acc + shadow[base + k];
    end
    return acc;
  endfunction

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic host_write(input logic [31:0] addr, input logic [63:0] data);
    @(posedge clock);
    host_we    <= 1'b1;
    host_addr  <= addr;
    host_wdata <= data;
    @(posedge clock);
    host_we <= 1'b0;
    shadow[addr[IDX_W+2:3]] = data;
  endtask

  // Read latency is fixed at one cycle, so the cycle count is part of the check
  task automatic mmio_read(input logic [1:0] idx, output logic [63:0] data);
    @(posedge clock);
    mmio_in <= '{valid: 1'b1, write: 1'b0, index: idx, wdata: '0};
    @(negedge clock);
    check_value("read response before latency", 64'(mmio_out.valid), 64'd0);
    @(posedge clock);
    mmio_in <= '0;
    @(negedge clock);
    check_value("read response valid", 64'(mmio_out.valid), 64'd1);
    data = mmio_out.rdata;
    @(negedge clock);
    check_value("read response single cycle", 64'(mmio_out.valid), 64'd0);
  endtask

  task automatic mmio_write(input logic [1:0] idx, input mmio_wdata_u data);
    @(posedge clock);
    mmio_in <= '{valid: 1'b1, write: 1'b1, index: idx, wdata: data};
    @(posedge clock);
    mmio_in <= '0;
  endtask

  task automatic wait_done(input int n, output logic seen);
    logic [63:0] bits;
    seen = 1'b0;
    for (int cyc = 0; cyc < DONE_TIMEOUT && !seen; cyc++) begin
      @(posedge clock);
      // New ack delay every cycle in random mode
      if (rand_mode) begin
        take_bits(4, bits);
        ack_delay <= bits[3:0];
      end
      @(negedge clock);
      seen = job_out.done;
    end
    if (!seen) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: job %0d never raised done", n);
    end
  endtask

  task automatic wait_idle(input int n, output logic seen);
    seen = 1'b0;
    for (int cyc = 0; cyc < IDLE_TIMEOUT && !seen; cyc++) begin
      @(negedge clock);
      seen = (job_out == '0);
    end
    if (!seen) begin
      errors++;
      timed_out = 1'b1;
      $display("Timeout: soft reset after job %0d did not return the unit to idle", n);
    end
  endtask

  //////////////////////////////
  // One job from the table
  //////////////////////////////

  task automatic run_job(input int n);
    job_entry_t  j;
    logic [63:0] exp_sum;
    logic [63:0] marker;
    logic [63:0] rd;
    mmio_wdata_u wword;
    logic        seen;
    j       = jobs[n];
    marker  = {16'hdead, 16'(n), j.dst};
    exp_sum = '0;
    host_write(j.wed_addr, {j.count, j.src});
    host_write(j.wed_addr + 32'd8, {32'h0, j.dst});
    host_write(j.dst, marker);
    if (j.exp_err == '0) begin
      exp_sum = sum_words(j.src, j.count);
    end
    rand_mode = j.rand_delay;
    @(posedge clock);
    err_en    <= j.inject;
    err_addr  <= j.err_addr;
    ack_delay <= '0;
    job_in    <= '{start: 1'b1, wed_addr: j.wed_addr};
    @(posedge clock);
    job_in.start <= 1'b0;
    mmio_read(REG_STATUS, rd);
    check_value("status while running", rd, 64'h1);
    wait_done(n, seen);
    if (!seen) begin
      return;
    end
    rand_mode = 1'b0;
    // Faulted jobs leave the destination marker in place
    if (j.exp_err == '0) begin
      check_value("destination word", u_mem.mem[j.dst[IDX_W+2:3]], exp_sum);
      shadow[j.dst[IDX_W+2:3]] = exp_sum;
      mmio_read(REG_RESULT, rd);
      check_value("result register", rd, exp_sum);
    end else begin
      check_value("destination untouched", u_mem.mem[j.dst[IDX_W+2:3]], marker);
    end
    mmio_read(REG_STATUS, rd);
    check_value("status after job", rd, 64'h2);
    mmio_read(REG_ERROR, rd);
    check_value("error register", rd, {60'h0, j.exp_err});
    if (j.exp_err != '0) begin
      wword                  = '0;
      wword.err_ack.clear_mask = j.exp_err;
      mmio_write(REG_ERROR, wword);
      mmio_read(REG_ERROR, rd);
      check_value("error register after clear", rd, 64'h0);
    end
    @(posedge clock);
    err_en <= 1'b0;
    if (j.soft_reset) begin
      wword                 = '0;
      wword.ctrl.soft_reset = 1'b1;
      mmio_write(REG_CTRL, wword);
      wait_idle(n, seen);
      if (!seen) begin
        return;
      end
      mmio_read(REG_STATUS, rd);
      check_value("status after soft reset", rd, 64'h0);
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    logic [63:0] fill_word;
    clock      = 1'b0;
    rst        = 1'b1;
    job_in     = '0;
    mmio_in    = '0;
    ack_delay  = '0;
    err_en     = 1'b0;
    err_addr   = '0;
    host_we    = 1'b0;
    host_addr  = '0;
    host_wdata = '0;
    lfsr       = 32'h42af;
    rand_mode  = 1'b0;
    timed_out  = 1'b0;
    errors     = 0;
    checks     = 0;

    // wed, src, count, dst, inject, err addr, error mask, soft reset, random delay
    jobs = '{
      '{32'h000, 32'h200, 32'd1,  32'h700, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b0},
      '{32'h010, 32'h208, 32'd5,  32'h708, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b0},
      '{32'h020, 32'h200, 32'd64, 32'h710, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b0},
      '{32'h030, 32'h300, 32'd0,  32'h718, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b0},
      '{32'h040, 32'h200, 32'd65, 32'h720, 1'b0, 32'h000, 4'b1000, 1'b0, 1'b0},
      '{32'h050, 32'h200, 32'd3,  32'h728, 1'b1, 32'h058, 4'b0001, 1'b0, 1'b0},
      '{32'h060, 32'h280, 32'd4,  32'h730, 1'b1, 32'h290, 4'b0010, 1'b0, 1'b0},
      '{32'h070, 32'h208, 32'd5,  32'h738, 1'b0, 32'h000, 4'b0000, 1'b1, 1'b0},
      '{32'h080, 32'h200, 32'd1,  32'h740, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b1},
      '{32'h090, 32'h208, 32'd5,  32'h748, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b1},
      '{32'h0a0, 32'h200, 32'd64, 32'h750, 1'b0, 32'h000, 4'b0000, 1'b0, 1'b1},
      '{32'h0b0, 32'h280, 32'd4,  32'h758, 1'b1, 32'h290, 4'b0010, 1'b1, 1'b1}
    };

    repeat (3) @(posedge clock);
    rst <= 1'b0;
    @(negedge clock);
    check_value("mem_req after reset", 64'(mem_req), 64'd0);
    check_value("job_out after reset", 64'(job_out), 64'd0);
    check_value("mmio valid after reset", 64'(mmio_out.valid), 64'd0);

    // Memory fill mixes LFSR bits with the byte address
    for (int a = 0; a < MEM_WORDS; a++) begin
      take_bits(64, fill_word);
      host_write(32'(a * 8), fill_word ^ 64'(a * 8));
    end

    for (int n = 0; n < NUM_JOBS; n++) begin
      run_job(n);
      if (timed_out) begin
        break;
      end
    end

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
afu_pkg.sv
mmio_pkg.sv
job_control.sv
wed_fetch.sv
sum_unit.sv
mem_arbiter.sv
mmio_regs.sv
afu_top.sv
tb_mem_model.sv
tb_afu.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        := tb_afu
FILELIST   := project.f
LINT_FLAGS := --lint-only -Wall --timing --assert
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '*** TEST PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
